//--- Makefile
# Verilator build and run for the nf_cpu testbench.
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= nf_cpu_tb
FILELIST  ?= nf_cpu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test passed

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

check:
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || { echo "FAIL"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/nf_cpu.sv
// Top level of the five-stage RV32I subset core.
// Connects fetch, decode, execute, mem/wb and the hazard unit.
// Both memories must answer combinationally in the cycle of the request.

`timescale 1ns/1ns
`include "nf_cpu_defines.svh"

module nf_cpu (
    input  logic               clk,            // core clock
    input  logic               reset_i,        // sync reset, active high
    output nf_cpu_pkg::word_t  imem_addr_o,    // instruction address
    input  nf_cpu_pkg::word_t  imem_rd_i,      // instruction word
    output nf_cpu_pkg::word_t  dmem_addr_o,    // data address
    input  nf_cpu_pkg::word_t  dmem_rd_i,      // load data
    output nf_cpu_pkg::word_t  dmem_wd_o,      // store data
    output logic               dmem_we_o,      // store strobe
    output logic               dmem_req_o      // load or store strobe
);

    nf_cpu_pkg::word_t      instr_id;       // if/id instruction
    nf_cpu_pkg::reg_addr_t  rs1_id;         // decode sources for stall check
    nf_cpu_pkg::reg_addr_t  rs2_id;
    nf_cpu_pkg::word_t      rd1_ex;         // id/ex contents
    nf_cpu_pkg::word_t      rd2_ex;
    nf_cpu_pkg::word_t      imm_ex;
    nf_cpu_pkg::alu_op_t    alu_op_ex;
    logic                   src_b_imm_ex;
    logic                   we_rf_ex;
    logic                   load_ex;
    logic                   store_ex;
    nf_cpu_pkg::reg_addr_t  rd_addr_ex;
    nf_cpu_pkg::reg_addr_t  rs1_ex;
    nf_cpu_pkg::reg_addr_t  rs2_ex;
    nf_cpu_pkg::word_t      result_mem;     // ex/mem contents
    nf_cpu_pkg::word_t      store_data_mem;
    nf_cpu_pkg::reg_addr_t  rd_addr_mem;
    logic                   we_rf_mem;
    logic                   load_mem;
    logic                   store_mem;
    nf_cpu_pkg::reg_addr_t  ex_rd_addr;     // ex view for the hazard unit
    logic                   ex_load;
    nf_cpu_pkg::reg_addr_t  mem_rd_addr;    // mem stage forwarding source
    logic                   mem_we;
    nf_cpu_pkg::word_t      mem_result;
    nf_cpu_pkg::reg_addr_t  wb_addr;        // register file write port
    nf_cpu_pkg::word_t      wb_data;
    logic                   wb_we;
    logic                   stall;          // load-use hold of pc and if/id
    logic                   bubble;         // load-use nop into id/ex
    nf_cpu_pkg::fwd_sel_t   fwd_a;
    nf_cpu_pkg::fwd_sel_t   fwd_b;

    nf_fetch_stage fetch_0 (
        .clk(clk), .reset_i(reset_i), .stall_i(stall),
        .imem_addr_o(imem_addr_o), .imem_rd_i(imem_rd_i), .instr_o(instr_id)
    );

    nf_decode_stage decode_0 (
        .clk(clk), .reset_i(reset_i), .instr_i(instr_id), .bubble_i(bubble),
        .rs1_id_o(rs1_id), .rs2_id_o(rs2_id),
        .wb_addr_i(wb_addr), .wb_data_i(wb_data), .wb_we_i(wb_we),
        .rd1_o(rd1_ex), .rd2_o(rd2_ex), .imm_o(imm_ex), .alu_op_o(alu_op_ex),
        .src_b_imm_o(src_b_imm_ex), .we_rf_o(we_rf_ex), .load_o(load_ex),
        .store_o(store_ex), .rd_addr_o(rd_addr_ex), .rs1_o(rs1_ex), .rs2_o(rs2_ex)
    );

    nf_execute_stage execute_0 (
        .clk(clk), .reset_i(reset_i),
        .rd1_i(rd1_ex), .rd2_i(rd2_ex), .imm_i(imm_ex), .alu_op_i(alu_op_ex),
        .src_b_imm_i(src_b_imm_ex), .we_rf_i(we_rf_ex), .load_i(load_ex),
        .store_i(store_ex), .rd_addr_i(rd_addr_ex),
        .fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .mem_result_i(mem_result), .wb_data_i(wb_data),
        .result_o(result_mem), .store_data_o(store_data_mem), .rd_addr_o(rd_addr_mem),
        .we_rf_o(we_rf_mem), .load_o(load_mem), .store_o(store_mem),
        .ex_rd_addr_o(ex_rd_addr), .ex_load_o(ex_load)
    );

    nf_mem_wb_stage mem_wb_0 (
        .clk(clk), .reset_i(reset_i),
        .result_i(result_mem), .store_data_i(store_data_mem), .rd_addr_i(rd_addr_mem),
        .we_rf_i(we_rf_mem), .load_i(load_mem), .store_i(store_mem),
        .dmem_addr_o(dmem_addr_o), .dmem_wd_o(dmem_wd_o), .dmem_we_o(dmem_we_o),
        .dmem_req_o(dmem_req_o), .dmem_rd_i(dmem_rd_i),
        .mem_rd_addr_o(mem_rd_addr), .mem_we_o(mem_we), .mem_result_o(mem_result),
        .wb_addr_o(wb_addr), .wb_data_o(wb_data), .wb_we_o(wb_we)
    );

    nf_hazard_unit hazard_0 (
        .rs1_id_i(rs1_id), .rs2_id_i(rs2_id), .rs1_ex_i(rs1_ex), .rs2_ex_i(rs2_ex),
        .ex_rd_addr_i(ex_rd_addr), .mem_rd_addr_i(mem_rd_addr), .wb_rd_addr_i(wb_addr),
        .ex_load_i(ex_load), .mem_we_i(mem_we), .wb_we_i(wb_we),
        .stall_o(stall), .bubble_o(bubble), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
    );

endmodule : nf_cpu

//--- logic/nf_cpu_defines.svh
// Shared constants for the nf_cpu pipeline.
// Included by every RTL module and by the testbench for the data width.

`ifndef NF_CPU_DEFINES_SVH
`define NF_CPU_DEFINES_SVH

`define NF_XLEN         32              // data word width
`define NF_RF_AW        5               // register index width
`define NF_RESET_PC     32'h0000_0000   // first fetch address
`define NF_PC_STEP      32'd4           // one instruction per word

`define NF_OP_R         7'b0110011      // register-register alu
`define NF_OP_I         7'b0010011      // register-immediate alu
`define NF_OP_LUI       7'b0110111      // load upper immediate
`define NF_OP_LOAD      7'b0000011      // lw
`define NF_OP_STORE     7'b0100011      // sw

`define NF_F3_ADD       3'b000          // add sub addi
`define NF_F3_SLT       3'b010          // signed compare
`define NF_F3_XOR       3'b100
`define NF_F3_OR        3'b110
`define NF_F3_AND       3'b111
`define NF_F7_SUB       1'b1            // funct7 bit 30 for sub

`endif

//--- logic/nf_cpu_pkg.sv
// Types shared between the nf_cpu pipeline stages.
// Referenced with scoped names from each module.

package nf_cpu_pkg;

    typedef logic [31:0] word_t;        // data word or byte address
    typedef logic [4:0]  reg_addr_t;    // register file index

    // alu operation, decoded in id and applied in ex
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,              // also address calc for lw and sw
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,              // signed
        ALU_PASS_B = 3'd6               // lui result is the immediate
    } alu_op_t;

    // operand source in ex
    // 0 register value, 1 mem stage result, 2 write-back data
    typedef logic [1:0] fwd_sel_t;

endpackage : nf_cpu_pkg

//--- logic/nf_decode_stage.sv
// Decode stage. Instruction decoder, 32 entry register file and id/ex register.
// The register file is write-first so a write-back in this cycle is seen here.
// A bubble loads a nop into id/ex.

`timescale 1ns/1ns
`include "nf_cpu_defines.svh"

module nf_decode_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  nf_cpu_pkg::word_t      instr_i,        // from if/id
    input  logic                   bubble_i,       // load-use nop
    output nf_cpu_pkg::reg_addr_t  rs1_id_o,       // sources used by this instruction
    output nf_cpu_pkg::reg_addr_t  rs2_id_o,
    input  nf_cpu_pkg::reg_addr_t  wb_addr_i,      // register file write port
    input  nf_cpu_pkg::word_t      wb_data_i,
    input  logic                   wb_we_i,
    output nf_cpu_pkg::word_t      rd1_o,          // id/ex register
    output nf_cpu_pkg::word_t      rd2_o,
    output nf_cpu_pkg::word_t      imm_o,
    output nf_cpu_pkg::alu_op_t    alu_op_o,
    output logic                   src_b_imm_o,
    output logic                   we_rf_o,
    output logic                   load_o,
    output logic                   store_o,
    output nf_cpu_pkg::reg_addr_t  rd_addr_o,
    output nf_cpu_pkg::reg_addr_t  rs1_o,
    output nf_cpu_pkg::reg_addr_t  rs2_o
);

    nf_cpu_pkg::word_t      regs [0:(1 << `NF_RF_AW) - 1];  // x0 entry never read
    nf_cpu_pkg::alu_op_t    alu_f3;         // op from funct3 alone
    nf_cpu_pkg::alu_op_t    alu_op;
    nf_cpu_pkg::word_t      imm;
    nf_cpu_pkg::word_t      rd1;
    nf_cpu_pkg::word_t      rd2;
    logic                   src_b_imm;
    logic                   we_rf;
    logic                   load;
    logic                   store;
    logic                   use_rs1;
    logic                   use_rs2;

    function automatic nf_cpu_pkg::word_t rf_read(input nf_cpu_pkg::reg_addr_t addr);
        if (addr == '0)
            return '0;                              // x0 is hardwired
        else if (wb_we_i && (addr == wb_addr_i))
            return wb_data_i;                       // write-first bypass
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_we_i && (wb_addr_i != '0)) begin
            regs[wb_addr_i] <= wb_data_i;           // writes to x0 dropped
        end
    end

    always_comb begin
        case (instr_i[14:12])
            `NF_F3_SLT: alu_f3 = nf_cpu_pkg::ALU_SLT;
            `NF_F3_XOR: alu_f3 = nf_cpu_pkg::ALU_XOR;
            `NF_F3_OR:  alu_f3 = nf_cpu_pkg::ALU_OR;
            `NF_F3_AND: alu_f3 = nf_cpu_pkg::ALU_AND;
            default:    alu_f3 = nf_cpu_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        alu_op    = nf_cpu_pkg::ALU_ADD;
        imm       = '0;
        src_b_imm = 1'b0;
        we_rf     = 1'b0;
        load      = 1'b0;
        store     = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        case (instr_i[6:0])
            `NF_OP_R: begin
                we_rf   = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if ((instr_i[14:12] == `NF_F3_ADD) && (instr_i[30] == `NF_F7_SUB))
                    alu_op = nf_cpu_pkg::ALU_SUB;
                else
                    alu_op = alu_f3;
            end
            `NF_OP_I: begin
                alu_op    = alu_f3;                 // bit 30 is immediate here
                imm       = {{(`NF_XLEN - 12){instr_i[31]}}, instr_i[31:20]};
                src_b_imm = 1'b1;
                we_rf     = 1'b1;
                use_rs1   = 1'b1;
            end
            `NF_OP_LUI: begin
                alu_op    = nf_cpu_pkg::ALU_PASS_B;
                imm       = {instr_i[31:12], 12'b0};
                src_b_imm = 1'b1;
                we_rf     = 1'b1;
            end
            `NF_OP_LOAD: begin
                imm       = {{(`NF_XLEN - 12){instr_i[31]}}, instr_i[31:20]};
                src_b_imm = 1'b1;
                we_rf     = 1'b1;
                load      = 1'b1;
                use_rs1   = 1'b1;
            end
            `NF_OP_STORE: begin
                imm       = {{(`NF_XLEN - 12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                src_b_imm = 1'b1;
                store     = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;                   // store data
            end
            default: ;                              // unknown opcode is a nop
        endcase
    end

    // unused source fields masked so lui and i-type never cause false hazards
    assign rs1_id_o = use_rs1 ? instr_i[19:15] : '0;
    assign rs2_id_o = use_rs2 ? instr_i[24:20] : '0;

    always_comb begin
        rd1 = rf_read(rs1_id_o);
        rd2 = rf_read(rs2_id_o);
    end

    always_ff @(posedge clk) begin
        if (reset_i || bubble_i) begin
            rd1_o       <= '0;
            rd2_o       <= '0;
            imm_o       <= '0;
            alu_op_o    <= nf_cpu_pkg::ALU_ADD;
            src_b_imm_o <= 1'b0;
            we_rf_o     <= 1'b0;
            load_o      <= 1'b0;
            store_o     <= 1'b0;
            rd_addr_o   <= '0;
            rs1_o       <= '0;
            rs2_o       <= '0;
        end else begin
            rd1_o       <= rd1;
            rd2_o       <= rd2;
            imm_o       <= imm;
            alu_op_o    <= alu_op;
            src_b_imm_o <= src_b_imm;
            we_rf_o     <= we_rf;
            load_o      <= load;
            store_o     <= store;
            rd_addr_o   <= we_rf ? instr_i[11:7] : '0;    // stores have no rd
            rs1_o       <= rs1_id_o;
            rs2_o       <= rs2_id_o;
        end
    end

endmodule : nf_decode_stage

//--- logic/nf_execute_stage.sv
// Execute stage. Operand forwarding, alu and the ex/mem register.
// For lw and sw the alu result is the data memory address.

`timescale 1ns/1ns
`include "nf_cpu_defines.svh"

module nf_execute_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  nf_cpu_pkg::word_t      rd1_i,          // id/ex contents
    input  nf_cpu_pkg::word_t      rd2_i,
    input  nf_cpu_pkg::word_t      imm_i,
    input  nf_cpu_pkg::alu_op_t    alu_op_i,
    input  logic                   src_b_imm_i,
    input  logic                   we_rf_i,
    input  logic                   load_i,
    input  logic                   store_i,
    input  nf_cpu_pkg::reg_addr_t  rd_addr_i,
    input  nf_cpu_pkg::fwd_sel_t   fwd_a_i,        // operand a source
    input  nf_cpu_pkg::fwd_sel_t   fwd_b_i,        // operand b and store data source
    input  nf_cpu_pkg::word_t      mem_result_i,   // ex/mem result
    input  nf_cpu_pkg::word_t      wb_data_i,      // write-back data
    output nf_cpu_pkg::word_t      result_o,       // ex/mem register
    output nf_cpu_pkg::word_t      store_data_o,
    output nf_cpu_pkg::reg_addr_t  rd_addr_o,
    output logic                   we_rf_o,
    output logic                   load_o,
    output logic                   store_o,
    output nf_cpu_pkg::reg_addr_t  ex_rd_addr_o,   // instruction now in ex
    output logic                   ex_load_o
);

    nf_cpu_pkg::word_t  src_a;
    nf_cpu_pkg::word_t  rs2_val;                    // forwarded rs2 for sw
    nf_cpu_pkg::word_t  src_b;
    nf_cpu_pkg::word_t  alu_res;

    function automatic nf_cpu_pkg::word_t fwd_mux(input nf_cpu_pkg::fwd_sel_t sel,
                                                  input nf_cpu_pkg::word_t rf_val);
        case (sel)
            2'd1:    return mem_result_i;
            2'd2:    return wb_data_i;
            default: return rf_val;
        endcase
    endfunction

    always_comb begin
        src_a   = fwd_mux(fwd_a_i, rd1_i);
        rs2_val = fwd_mux(fwd_b_i, rd2_i);
        src_b   = src_b_imm_i ? imm_i : rs2_val;
        case (alu_op_i)
            nf_cpu_pkg::ALU_SUB:    alu_res = src_a - src_b;
            nf_cpu_pkg::ALU_AND:    alu_res = src_a & src_b;
            nf_cpu_pkg::ALU_OR:     alu_res = src_a | src_b;
            nf_cpu_pkg::ALU_XOR:    alu_res = src_a ^ src_b;
            nf_cpu_pkg::ALU_SLT:    alu_res = {{(`NF_XLEN - 1){1'b0}},
                                               $signed(src_a) < $signed(src_b)};
            nf_cpu_pkg::ALU_PASS_B: alu_res = src_b;
            default:                alu_res = src_a + src_b;
        endcase
    end

    assign ex_rd_addr_o = rd_addr_i;                // load-use check in hazard unit
    assign ex_load_o    = load_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            result_o     <= '0;
            store_data_o <= '0;
            rd_addr_o    <= '0;
            we_rf_o      <= 1'b0;
            load_o       <= 1'b0;
            store_o      <= 1'b0;
        end else begin
            result_o     <= alu_res;
            store_data_o <= rs2_val;
            rd_addr_o    <= rd_addr_i;
            we_rf_o      <= we_rf_i;
            load_o       <= load_i;
            store_o      <= store_i;
        end
    end

endmodule : nf_execute_stage

//--- logic/nf_fetch_stage.sv
// Fetch stage. Program counter and the if/id instruction register.
// Instruction memory is read combinationally at imem_addr_o.

`timescale 1ns/1ns
`include "nf_cpu_defines.svh"

module nf_fetch_stage (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               stall_i,        // load-use hold
    output nf_cpu_pkg::word_t  imem_addr_o,    // current pc
    input  nf_cpu_pkg::word_t  imem_rd_i,      // word at the current pc
    output nf_cpu_pkg::word_t  instr_o         // if/id instruction
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            imem_addr_o <= `NF_RESET_PC;
            instr_o     <= '0;                          // opcode 0 decodes as a nop
        end else if (!stall_i) begin
            imem_addr_o <= imem_addr_o + `NF_PC_STEP;   // sequential only
            instr_o     <= imem_rd_i;
        end
    end

endmodule : nf_fetch_stage

//--- logic/nf_hazard_unit.sv
// Hazard unit. Load-use stall detection and ex operand forwarding select.
// Purely combinational.

`timescale 1ns/1ns
`include "nf_cpu_defines.svh"

module nf_hazard_unit (
    input  nf_cpu_pkg::reg_addr_t  rs1_id_i,       // sources in decode
    input  nf_cpu_pkg::reg_addr_t  rs2_id_i,
    input  nf_cpu_pkg::reg_addr_t  rs1_ex_i,       // sources in execute
    input  nf_cpu_pkg::reg_addr_t  rs2_ex_i,
    input  nf_cpu_pkg::reg_addr_t  ex_rd_addr_i,
    input  nf_cpu_pkg::reg_addr_t  mem_rd_addr_i,
    input  nf_cpu_pkg::reg_addr_t  wb_rd_addr_i,
    input  logic                   ex_load_i,
    input  logic                   mem_we_i,
    input  logic                   wb_we_i,
    output logic                   stall_o,        // hold pc and if/id
    output logic                   bubble_o,       // nop into id/ex
    output nf_cpu_pkg::fwd_sel_t   fwd_a_o,
    output nf_cpu_pkg::fwd_sel_t   fwd_b_o
);

    logic load_use;

    // youngest producer wins
    function automatic nf_cpu_pkg::fwd_sel_t fwd_pick(input nf_cpu_pkg::reg_addr_t rs);
        if (mem_we_i && (mem_rd_addr_i != '0) && (mem_rd_addr_i == rs))
            return 2'd1;
        else if (wb_we_i && (wb_rd_addr_i != '0) && (wb_rd_addr_i == rs))
            return 2'd2;
        else
            return 2'd0;
    endfunction

    // lw in ex feeding the instruction in id, data not ready until wb
    assign load_use = ex_load_i && (ex_rd_addr_i != '0) &&
                      ((ex_rd_addr_i == rs1_id_i) || (ex_rd_addr_i == rs2_id_i));
    assign stall_o  = load_use;
    assign bubble_o = load_use;

    always_comb begin
        fwd_a_o = fwd_pick(rs1_ex_i);
        fwd_b_o = fwd_pick(rs2_ex_i);
    end

endmodule : nf_hazard_unit

//--- logic/nf_mem_wb_stage.sv
// Memory and write-back stage. Drives data memory strobes from ex/mem,
// registers into mem/wb and selects load data or alu result for write-back.

`timescale 1ns/1ns
`include "nf_cpu_defines.svh"

module nf_mem_wb_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  nf_cpu_pkg::word_t      result_i,       // ex/mem contents
    input  nf_cpu_pkg::word_t      store_data_i,
    input  nf_cpu_pkg::reg_addr_t  rd_addr_i,
    input  logic                   we_rf_i,
    input  logic                   load_i,
    input  logic                   store_i,
    output nf_cpu_pkg::word_t      dmem_addr_o,
    output nf_cpu_pkg::word_t      dmem_wd_o,
    output logic                   dmem_we_o,
    output logic                   dmem_req_o,
    input  nf_cpu_pkg::word_t      dmem_rd_i,      // answered in the same cycle
    output nf_cpu_pkg::reg_addr_t  mem_rd_addr_o,  // mem stage forwarding source
    output logic                   mem_we_o,
    output nf_cpu_pkg::word_t      mem_result_o,
    output nf_cpu_pkg::reg_addr_t  wb_addr_o,      // register file write port
    output nf_cpu_pkg::word_t      wb_data_o,
    output logic                   wb_we_o
);

    nf_cpu_pkg::word_t  wb_result;
    nf_cpu_pkg::word_t  wb_load_data;
    logic               wb_load;

    assign dmem_addr_o   = result_i;
    assign dmem_wd_o     = store_data_i;
    assign dmem_we_o     = store_i;
    assign dmem_req_o    = store_i || load_i;
    assign mem_rd_addr_o = rd_addr_i;
    assign mem_we_o      = we_rf_i;
    assign mem_result_o  = result_i;                // never a load here when forwarded

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_result    <= '0;
            wb_load_data <= '0;
            wb_addr_o    <= '0;
            wb_we_o      <= 1'b0;
            wb_load      <= 1'b0;
        end else begin
            wb_result    <= result_i;
            wb_load_data <= dmem_rd_i;
            wb_addr_o    <= rd_addr_i;
            wb_we_o      <= we_rf_i;
            wb_load      <= load_i;
        end
    end

    assign wb_data_o = wb_load ? wb_load_data : wb_result;

endmodule : nf_mem_wb_stage

//--- nf_cpu.f
+incdir+logic
logic/nf_cpu_pkg.sv
logic/nf_fetch_stage.sv
logic/nf_decode_stage.sv
logic/nf_execute_stage.sv
logic/nf_hazard_unit.sv
logic/nf_mem_wb_stage.sv
logic/nf_cpu.sv
testbench/nf_clock_gen.sv
testbench/nf_cpu_tb.sv

//--- testbench/nf_clock_gen.sv
// Clock and reset source for the nf_cpu testbench.
// 10 ns clock, reset held high over the first two rising edges.

`timescale 1ns/1ns

module nf_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    localparam int HALF_PERIOD  = 5;    // 10 ns period
    localparam int RESET_CYCLES = 2;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 reset_o = 1'b0;              // released just after the edge like other inputs
    end

endmodule : nf_clock_gen

//--- testbench/nf_cpu_patterns.txt
// word 0 program length, word 1 store count (hex)
// program words from 0x10, expected stores from 0x40 as pairs: address data
@00
0000001C 0000000C
@10
10000513 // addi x10, x0, 256    data base
00500093 // addi x1, x0, 5
FFD00113 // addi x2, x0, -3
002081B3 // add  x3, x1, x2      x2 from mem stage, x1 from wb
00352023 // sw   x3, 0(x10)      store data forwarded
40208233 // sub  x4, x1, x2
00452223 // sw   x4, 4(x10)
0020F2B3 // and  x5, x1, x2
00552423 // sw   x5, 8(x10)
0020E333 // or   x6, x1, x2
00652623 // sw   x6, 12(x10)
0020C3B3 // xor  x7, x1, x2
00752823 // sw   x7, 16(x10)
00112433 // slt  x8, x2, x1      -3 < 5
00852A23 // sw   x8, 20(x10)
0F017493 // andi x9, x2, 0x0f0
F000E593 // ori  x11, x1, -256
7FF0C613 // xori x12, x1, 0x7ff
00952C23 // sw   x9, 24(x10)
00B52E23 // sw   x11, 28(x10)
02C52023 // sw   x12, 32(x10)
ABCDE6B7 // lui  x13, 0xabcde
FED52E23 // sw   x13, -4(x10)    negative offset
00052703 // lw   x14, 0(x10)
001707B3 // add  x15, x14, x1    load-use stall
02F52223 // sw   x15, 36(x10)
07B00013 // addi x0, x0, 123     dropped
02052423 // sw   x0, 40(x10)
@40
00000100 00000002
00000104 00000008
00000108 00000005
0000010C FFFFFFFD
00000110 FFFFFFF8
00000114 00000001
00000118 000000F0
0000011C FFFFFF05
00000120 000007FA
000000FC ABCDE000
00000124 00000007
00000128 00000000

//--- testbench/nf_cpu_tb.sv
// Testbench for the nf_cpu pipeline.
// Runs the program from the pattern file out of a combinational instruction ROM
// and compares every data-memory store, in order, with the expected address/data pairs.

`timescale 1ns/1ns
`include "nf_cpu_defines.svh"

module nf_cpu_tb;

    localparam string PATTERN_FILE = "testbench/nf_cpu_patterns.txt";
    localparam int PAT_WORDS  = 128;
    localparam int PROG_BASE  = 'h10;   // first program word in the pattern file
    localparam int EXP_BASE   = 'h40;   // first expected store pair
    localparam int MAX_STORES = (PAT_WORDS - EXP_BASE) / 2;
    localparam int MEM_WORDS  = 256;    // both memories decode addr[9:2]

    logic               clk;
    logic               reset_i;
    logic [`NF_XLEN-1:0] imem_addr;
    logic [`NF_XLEN-1:0] imem_rd;
    logic [`NF_XLEN-1:0] dmem_addr;
    logic [`NF_XLEN-1:0] dmem_rd;
    logic [`NF_XLEN-1:0] dmem_wd;
    logic               dmem_we;
    logic               dmem_req;

    logic [`NF_XLEN-1:0] pat [0:PAT_WORDS-1];       // raw pattern file image
    logic [`NF_XLEN-1:0] prog_rom [0:MEM_WORDS-1];
    logic [`NF_XLEN-1:0] exp_store [0:2*MAX_STORES-1];  // addr, data, addr, data ...
    logic [`NF_XLEN-1:0] dmem [0:MEM_WORDS-1];
    int prog_len;
    int store_cnt;
    int stores_seen;
    int load_cnt;                       // lw words in the program
    int loads_seen;                     // req pulses without we
    int errors;
    int checks;
    int cycles;
    int limit;
    int reset_errs;

    nf_clock_gen clock_0 (.clk_o(clk), .reset_o(reset_i));

    nf_cpu uut (
        .clk(clk), .reset_i(reset_i),
        .imem_addr_o(imem_addr), .imem_rd_i(imem_rd),
        .dmem_addr_o(dmem_addr), .dmem_rd_i(dmem_rd), .dmem_wd_o(dmem_wd),
        .dmem_we_o(dmem_we), .dmem_req_o(dmem_req)
    );

    // memory answers, driven 1 ns after each rising edge
    // both addresses come from registers so they are stable by then
    initial begin
        imem_rd = '0;
        dmem_rd = '0;
        forever begin
            @(posedge clk);
            #1;
            imem_rd = prog_rom[imem_addr[9:2]];
            dmem_rd = dmem[dmem_addr[9:2]];
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // called at the falling edge, mem stage outputs are settled
    task automatic sample_store();
        int errs_before;
        errs_before = errors;
        if (dmem_req && !dmem_we)
            loads_seen++;                       // load strobe
        if (dmem_we) begin
            if (stores_seen < store_cnt) begin
                check_value("dmem_addr_o", dmem_addr, exp_store[2*stores_seen]);
                check_value("dmem_wd_o", dmem_wd, exp_store[2*stores_seen+1]);
                check_value("dmem_req_o", 32'(dmem_req), 32'd1);    // req comes with every we
                $display("store %0d to %h: %s", stores_seen, dmem_addr,
                         (errors == errs_before) ? "ok" : "mismatch");
            end else begin
                errors++;
                $display("unexpected store of %h to %h after the last expected one",
                         dmem_wd, dmem_addr);
            end
            dmem[dmem_addr[9:2]] = dmem_wd;     // later lw reads it back
            stores_seen++;
        end
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        stores_seen = 0;
        load_cnt    = 0;
        loads_seen  = 0;
        cycles      = 0;
        for (int i = 0; i < PAT_WORDS; i++)
            pat[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog_rom[i] = '0;                   // opcode 0 runs as a nop past the program
            dmem[i]     = '0;
        end
        $readmemh(PATTERN_FILE, pat);
        prog_len  = pat[0];
        store_cnt = pat[1];
        if ((prog_len < 1) || (prog_len > EXP_BASE - PROG_BASE) || (store_cnt > MAX_STORES)) begin
            errors++;
            $display("pattern file is missing or its header counts are out of range");
            store_cnt = 0;
        end
        for (int i = 0; i < prog_len; i++) begin
            prog_rom[i] = pat[PROG_BASE + i];
            if (pat[PROG_BASE + i][6:0] == `NF_OP_LOAD)
                load_cnt++;
        end
        for (int i = 0; i < 2 * store_cnt; i++)
            exp_store[i] = pat[EXP_BASE + i];
        limit = 4 * prog_len + 20;

        // no memory strobes while in reset, fetch starts at the reset pc
        reset_errs = errors;
        @(posedge clk);
        @(negedge clk);
        while (reset_i) begin
            check_value("dmem_we_o", 32'(dmem_we), 32'd0);
            check_value("dmem_req_o", 32'(dmem_req), 32'd0);
            @(negedge clk);
        end
        check_value("imem_addr_o", imem_addr, `NF_RESET_PC);
        check_value("dmem_we_o", 32'(dmem_we), 32'd0);
        check_value("dmem_req_o", 32'(dmem_req), 32'd0);
        $display("reset: %s", (errors == reset_errs) ? "ok" : "mismatch");

        while ((stores_seen < store_cnt) && (cycles < limit)) begin
            @(negedge clk);
            cycles++;
            sample_store();
        end
        repeat (4) begin                        // a few nops to catch stray stores
            @(negedge clk);
            sample_store();
        end
        if (stores_seen < store_cnt) begin
            errors++;
            $display("timeout after %0d cycles, only %0d of %0d stores arrived",
                     cycles, stores_seen, store_cnt);
        end
        check_value("dmem_req_o load pulses", 32'(loads_seen), 32'(load_cnt));
        $display("load strobes %0d of %0d: %s", loads_seen, load_cnt,
                 (loads_seen == load_cnt) ? "ok" : "mismatch");

        $display("checks %0d, errors %0d, stores %0d of %0d, cycles %0d",
                 checks, errors, stores_seen, store_cnt, cycles);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : nf_cpu_tb
